//--- design/ptwPkg.sv
// Page table walker shared definitions
// Widths, SATP mode codes, page sizes and walker states for Sv39/Sv48

package ptwPkg;

  ////////////////////
  // Widths
  ////////////////////
  localparam int xlen       = 64;  // Register width
  localparam int paBits     = 56;  // Physical address
  localparam int ppnBits    = 44;  // Physical page number
  localparam int vpnBits    = 9;   // One VPN field per level
  localparam int svModeBits = 4;   // SATP.MODE field

  typedef logic [xlen-1:0]    xlenT;  // Addresses, SATP, PTEs
  typedef logic [paBits-1:0]  paT;
  typedef logic [ppnBits-1:0] ppnT;
  typedef logic [vpnBits-1:0] vpnT;

  ////////////////////
  // SATP modes
  ////////////////////
  localparam logic [svModeBits-1:0] sv39Mode = 4'd8;
  localparam logic [svModeBits-1:0] sv48Mode = 4'd9;

  // Size of the mapped page, follows the level where the leaf was found
  typedef logic [1:0] pageTypeT;
  localparam pageTypeT kiloPage = 2'd0;  // 4 KiB, level 0
  localparam pageTypeT megaPage = 2'd1;  // 2 MiB, level 1
  localparam pageTypeT gigaPage = 2'd2;  // 1 GiB, level 2
  localparam pageTypeT teraPage = 2'd3;  // 512 GiB, level 3 (Sv48 only)

  ////////////////////
  // Walker states
  ////////////////////
  // Each level has an address cycle and a read cycle that holds on stall
  typedef enum logic [3:0] {
    IDLE,
    L3_ADR, L3_RD,   // Sv48 root
    L2_ADR, L2_RD,   // Sv39 root
    L1_ADR, L1_RD,
    L0_ADR, L0_RD,
    LEAF,            // TLB write strobe
    FAULT            // One cycle, faults shown
  } walkStateT;

endpackage

//--- design/walkAddrGen.sv
// Page table walker address generator
// Picks the virtual address to translate and forms each PTE read address

`timescale 1ns/1ps

module walkAddrGen (
  input  logic              clk,
  input  logic              reset,
  input  logic              startWalk,   // Walk begins this cycle
  input  logic              dtlbMiss,
  input  ptwPkg::xlenT      pcAdr,       // Instruction side VA
  input  ptwPkg::xlenT      dataAdr,     // Data side VA
  input  ptwPkg::xlenT      satp,
  input  ptwPkg::walkStateT walkState,
  input  ptwPkg::ppnT       currentPpn,  // From the last captured PTE
  output ptwPkg::paT        ptwAdr,
  output logic              dtlbWalk
);
  import ptwPkg::*;

  logic [svModeBits-1:0] svMode;
  xlenT                  translationAdr;
  ppnT                   rootPpn;
  ppnT                   levelPpn;
  vpnT                   levelVpn;
  logic                  rootLevel;

  assign svMode  = satp[xlen-1 -: svModeBits];
  assign rootPpn = satp[ppnBits-1:0];  // Root table page

  // Remember which TLB asked, held for the whole walk
  always_ff @(posedge clk) begin
    if (reset) dtlbWalk <= 1'b0;
    else if (startWalk) dtlbWalk <= dtlbMiss;  // ITLB walk records 0
  end

  assign translationAdr = dtlbWalk ? dataAdr : pcAdr;

  // VPN field for the level being walked
  always_comb begin
    case (walkState)
      L3_ADR, L3_RD: levelVpn = translationAdr[47:39];
      L2_ADR, L2_RD: levelVpn = translationAdr[38:30];
      L1_ADR, L1_RD: levelVpn = translationAdr[29:21];
      default:       levelVpn = translationAdr[20:12];
    endcase
  end

  // First level of the active mode starts from SATP
  assign rootLevel = (walkState == L3_ADR) | (walkState == L3_RD) |
                     ((svMode != sv48Mode) & ((walkState == L2_ADR) | (walkState == L2_RD)));
  assign levelPpn  = rootLevel ? rootPpn : currentPpn;

  assign ptwAdr = {levelPpn, levelVpn, 3'b000};  // 8-byte PTE index

endmodule

//--- design/pteCapture.sv
// Page table entry capture
// Holds the entry read at the current level and decodes its type bits

`timescale 1ns/1ps

module pteCapture (
  input  logic         clk,
  input  logic         reset,
  input  logic         readEn,        // Walker read completes
  input  ptwPkg::xlenT readData,      // Entry from memory
  output ptwPkg::xlenT pte,
  output ptwPkg::ppnT  currentPpn,
  output logic         validNonLeaf,
  output logic         pbmtFault
);
  import ptwPkg::*;

  logic valid;
  logic readable;
  logic writable;
  logic executable;
  logic leafPte;

  ////////////////////
  // Entry register
  ////////////////////
  always_ff @(posedge clk) begin
    if (reset) pte <= '0;
    else if (readEn) pte <= readData;  // Load on the completing edge only
  end

  // Next level table base sits at PTE[53:10]
  assign currentPpn = pte[ppnBits+9:10];

  ////////////////////
  // Type decode
  ////////////////////
  assign valid      = pte[0];
  assign readable   = pte[1];
  assign writable   = pte[2];
  assign executable = pte[3];

  // Any of R/W/X makes it a leaf
  assign leafPte = readable | writable | executable;

  // Pointer to the next level
  assign validNonLeaf = valid & ~leafPte;

  // PBMT bits are reserved on non-leaf entries
  assign pbmtFault = validNonLeaf & (|pte[62:61]);

endmodule

//--- design/walkFsm.sv
// Page table walker control
// Steps through the levels, tracks page size and drives the TLB and LSU strobes

`timescale 1ns/1ps

module walkFsm (
  input  logic              clk,
  input  logic              reset,
  input  logic              flush,                   // Abort back to IDLE
  input  logic              itlbMiss,
  input  logic              dtlbMiss,
  input  ptwPkg::xlenT      satp,
  input  logic              memStall,                // Read not done yet
  input  logic              lsuLoadAccessFault,
  input  logic              lsuStoreAmoAccessFault,
  input  logic              validNonLeaf,
  input  logic              pbmtFault,
  input  logic              dtlbWalk,
  output ptwPkg::walkStateT walkState,
  output logic              startWalk,
  output logic              readEn,                  // Capture PTE
  output logic              walkFault,
  output ptwPkg::pageTypeT  pageType,
  output logic              itlbWrite,
  output logic              dtlbWrite,
  output logic              ptwRead,
  output logic              selPtw,
  output logic              ptwStall,
  output logic              ignoreRequest
);
  import ptwPkg::*;

  walkStateT nextState;
  walkStateT initialState;
  pageTypeT  nextPageType;
  logic      sv48;
  logic      tlbMiss;
  logic      accessFault;
  logic      firstRead;

  assign sv48         = satp[xlen-1 -: svModeBits] == sv48Mode;
  assign initialState = sv48 ? L3_ADR : L2_ADR;  // Sv39 starts one level lower
  assign tlbMiss      = itlbMiss | dtlbMiss;
  assign startWalk    = (walkState == IDLE) & tlbMiss;

  ////////////////////
  // Read strobes
  ////////////////////
  assign ptwRead = (walkState == L3_RD) | (walkState == L2_RD) |
                   (walkState == L1_RD) | (walkState == L0_RD);
  assign readEn  = ptwRead & ~memStall;  // First unstalled RD cycle

  // Root read has no earlier entry, so a stale PBMT flag is ignored there
  assign firstRead   = (walkState == L3_RD) | ((walkState == L2_RD) & ~sv48);
  assign accessFault = lsuLoadAccessFault | lsuStoreAmoAccessFault;
  assign walkFault   = readEn & (accessFault | (pbmtFault & ~firstRead));

  ////////////////////
  // State machine
  ////////////////////
  always_ff @(posedge clk) begin
    if (reset | flush) walkState <= IDLE;
    else walkState <= nextState;
  end

  always_comb begin
    nextState = walkState;  // RD states hold on stall
    case (walkState)
      IDLE:   if (tlbMiss) nextState = initialState;
      L3_ADR: nextState = L3_RD;  // Always read, Sv48 root
      L3_RD:  if (readEn) nextState = walkFault ? FAULT : L2_ADR;
      L2_ADR: nextState = ((initialState == L2_ADR) | validNonLeaf) ? L2_RD : LEAF;
      L2_RD:  if (readEn) nextState = walkFault ? FAULT : L1_ADR;
      L1_ADR: nextState = validNonLeaf ? L1_RD : LEAF;
      L1_RD:  if (readEn) nextState = walkFault ? FAULT : L0_ADR;
      L0_ADR: nextState = validNonLeaf ? L0_RD : LEAF;
      L0_RD:  if (readEn) nextState = walkFault ? FAULT : LEAF;
      LEAF:   nextState = IDLE;
      FAULT:  nextState = IDLE;
      default: nextState = IDLE;
    endcase
  end

  ////////////////////
  // Page size
  ////////////////////
  // Last level read decides the size of the leaf
  always_comb begin
    case (walkState)
      L3_RD:   nextPageType = teraPage;
      L2_RD:   nextPageType = gigaPage;
      L1_RD:   nextPageType = megaPage;
      L0_RD:   nextPageType = kiloPage;
      default: nextPageType = pageType;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) pageType <= kiloPage;
    else pageType <= nextPageType;
  end

  // One-cycle TLB fill to the requester
  assign itlbWrite = (walkState == LEAF) & ~dtlbWalk;
  assign dtlbWrite = (walkState == LEAF) & dtlbWalk;

  assign selPtw        = walkState != IDLE;  // Walker owns the LSU port
  assign ptwStall      = ((walkState != IDLE) & (walkState != FAULT)) | startWalk;
  assign ignoreRequest = startWalk | walkFault;  // Suppress core access

endmodule

//--- design/walkFaults.sv
// Page table walker fault mapping
// Sorts walk faults by requester and access kind, delays them, merges LSU faults

`timescale 1ns/1ps

module walkFaults (
  input  logic              clk,
  input  logic              reset,
  input  ptwPkg::walkStateT walkState,
  input  logic              walkFault,     // Completing read faulted
  input  logic              lsuAccess,     // Fault came from memory access
  input  logic              dtlbWalk,
  input  logic [1:0]        memRW,         // [1] read, [0] write/AMO
  input  logic              lsuLoadAccessFault,
  input  logic              lsuStoreAmoAccessFault,
  input  logic              lsuLoadPageFault,
  input  logic              lsuStorePageFault,
  output logic              loadAccessFault,
  output logic              storeAmoAccessFault,
  output logic              loadPageFault,
  output logic              storeAmoPageFault,
  output logic              instrAccessFault,
  output logic              instrPageFault
);
  import ptwPkg::*;

  logic       accessHit;
  logic       pageHit;
  logic       loadWalk;
  logic       storeWalk;
  logic       instrWalk;
  logic [5:0] walkFaultBits;
  logic [5:0] walkFaultDly;   // {ldAcc, stAcc, inAcc, ldPg, stPg, inPg}
  logic       takeWalkFault;

  assign accessHit = walkFault & lsuAccess;   // Memory said no
  assign pageHit   = walkFault & ~lsuAccess;  // PBMT on non-leaf

  // Who is asking and for what
  assign loadWalk  = dtlbWalk & memRW[1] & ~memRW[0];
  assign storeWalk = dtlbWalk & memRW[0];  // AMO counts as store
  assign instrWalk = ~dtlbWalk;

  assign walkFaultBits = {accessHit & loadWalk, accessHit & storeWalk, accessHit & instrWalk,
                          pageHit & loadWalk, pageHit & storeWalk, pageHit & instrWalk};

  // Multicycle anyway, so take it off the critical path
  always_ff @(posedge clk) begin
    if (reset) walkFaultDly <= '0;
    else walkFaultDly <= walkFaultBits;
  end

  assign takeWalkFault = walkState != IDLE;

  // Idle walker lets the LSU faults straight through
  assign loadAccessFault     = takeWalkFault ? walkFaultDly[5] : lsuLoadAccessFault;
  assign storeAmoAccessFault = takeWalkFault ? walkFaultDly[4] : lsuStoreAmoAccessFault;
  assign instrAccessFault    = takeWalkFault & walkFaultDly[3];
  assign loadPageFault       = takeWalkFault ? walkFaultDly[2] : lsuLoadPageFault;
  assign storeAmoPageFault   = takeWalkFault ? walkFaultDly[1] : lsuStorePageFault;
  assign instrPageFault      = takeWalkFault & walkFaultDly[0];

endmodule

//--- design/pageTableWalker.sv
// Hardware page table walker for Sv39/Sv48
// Reads one PTE per level through the LSU port and fills the requesting TLB

`timescale 1ns/1ps

module pageTableWalker (
  input  logic             clk,
  input  logic             reset,
  input  logic             itlbMiss,
  input  logic             dtlbMiss,
  input  logic [1:0]       memRW,
  input  ptwPkg::xlenT     satp,
  input  ptwPkg::xlenT     pcAdr,
  input  ptwPkg::xlenT     dataAdr,
  input  logic             flush,
  // Memory side
  output logic             ptwRead,
  output ptwPkg::paT       ptwAdr,
  input  ptwPkg::xlenT     readData,
  input  logic             memStall,
  input  logic             lsuLoadAccessFault,
  input  logic             lsuStoreAmoAccessFault,
  input  logic             lsuLoadPageFault,
  input  logic             lsuStorePageFault,
  // TLB fill
  output ptwPkg::xlenT     pte,
  output ptwPkg::pageTypeT pageType,
  output logic             itlbWrite,
  output logic             dtlbWrite,
  output logic             selPtw,
  output logic             ptwStall,
  output logic             ignoreRequest,
  // Faults
  output logic             loadAccessFault,
  output logic             storeAmoAccessFault,
  output logic             loadPageFault,
  output logic             storeAmoPageFault,
  output logic             instrAccessFault,
  output logic             instrPageFault
);
  import ptwPkg::*;

  walkStateT walkState;
  ppnT       currentPpn;
  logic      startWalk;
  logic      readEn;
  logic      walkFault;
  logic      dtlbWalk;
  logic      validNonLeaf;
  logic      pbmtFault;
  logic      lsuAccess;

  // Memory fault on the read, as opposed to a PBMT page fault
  assign lsuAccess = lsuLoadAccessFault | lsuStoreAmoAccessFault;

  walkAddrGen walkAddrGen_inst (
    .clk, .reset, .startWalk, .dtlbMiss, .pcAdr, .dataAdr, .satp,
    .walkState, .currentPpn, .ptwAdr, .dtlbWalk
  );

  pteCapture pteCapture_inst (
    .clk, .reset, .readEn, .readData, .pte, .currentPpn, .validNonLeaf, .pbmtFault
  );

  walkFsm walkFsm_inst (
    .clk, .reset, .flush, .itlbMiss, .dtlbMiss, .satp, .memStall,
    .lsuLoadAccessFault, .lsuStoreAmoAccessFault, .validNonLeaf, .pbmtFault, .dtlbWalk,
    .walkState, .startWalk, .readEn, .walkFault, .pageType, .itlbWrite, .dtlbWrite,
    .ptwRead, .selPtw, .ptwStall, .ignoreRequest
  );

  walkFaults walkFaults_inst (
    .clk, .reset, .walkState, .walkFault, .lsuAccess, .dtlbWalk, .memRW,
    .lsuLoadAccessFault, .lsuStoreAmoAccessFault, .lsuLoadPageFault, .lsuStorePageFault,
    .loadAccessFault, .storeAmoAccessFault, .loadPageFault, .storeAmoPageFault,
    .instrAccessFault, .instrPageFault
  );

endmodule

//--- sim/tbClock.sv
// Testbench clock and reset
// 10 ns clock, reset held high over the first two rising edges

`timescale 1ns/1ps

module tbClock (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clk);
    #1 reset = 1'b0;  // Released just after the second edge
  end

endmodule

//--- sim/tbChecker.sv
// Page table walker checker
// Follows each walk, checks read addresses, compares the TLB fill and the faults

`timescale 1ns/1ps

module tbChecker (
  input  logic             clk,
  input  logic             reset,
  input  logic             itlbMiss,
  input  logic             dtlbMiss,
  input  logic             ptwRead,
  input  logic             memStall,
  input  ptwPkg::paT       ptwAdr,
  input  ptwPkg::xlenT     readData,
  input  ptwPkg::xlenT     pte,
  input  ptwPkg::pageTypeT pageType,
  input  logic             itlbWrite,
  input  logic             dtlbWrite,
  input  logic             selPtw,
  input  logic             ptwStall,
  input  logic             ignoreRequest,
  input  logic [3:0]       lsuFaults,  // {loadAcc, storeAcc, loadPg, storePg} from the LSU
  input  logic [5:0]       faultVec,   // {instrAcc, instrPg, loadAcc, storeAcc, loadPg, storePg}
  output int               failCount
);
  import ptwPkg::*;

  string      name;
  xlenT       satpV;
  xlenT       va;
  xlenT       expPte;
  xlenT       gotPte;
  xlenT       heldPte;      // What the entry register should hold
  pageTypeT   expType;
  pageTypeT   gotType;
  logic       expData;
  logic [5:0] expFault;
  logic [5:0] faultSeen;
  ppnT        prevPpn;      // PPN of the last entry read
  logic       active;
  logic       pteKnown;
  int         startLevel;
  int         readIdx;
  int         adrErrors;
  int         cycleErrors;
  int         itlbCount;
  int         dtlbCount;
  int         faultCycles;
  int         passCount;

  initial begin
    active    = 1'b0;
    passCount = 0;
    failCount = 0;
  end

  task automatic startTest(input string testName, input xlenT satpIn, input xlenT vaIn,
                           input logic dataIn, input xlenT expPteIn, input pageTypeT expTypeIn,
                           input logic [5:0] expFaultIn);
    name        = testName;
    satpV       = satpIn;
    va          = vaIn;
    expData     = dataIn;
    expPte      = expPteIn;
    expType     = expTypeIn;
    expFault    = expFaultIn;
    startLevel  = (satpIn[xlen-1 -: svModeBits] == sv48Mode) ? 3 : 2;  // Sv48 has 4 levels
    readIdx     = 0;
    adrErrors   = 0;
    cycleErrors = 0;
    itlbCount   = 0;
    dtlbCount   = 0;
    faultCycles = 0;
    faultSeen   = '0;
    gotPte      = '0;
    gotType     = '0;
    pteKnown    = 1'b0;  // Entry register still holds the last walk
    active      = 1'b1;
  endtask

  // Only the first per-cycle mismatch of a test gets a line
  task automatic cycleMismatch(input string what, input xlenT expV, input xlenT gotV);
    if (cycleErrors == 0)
      $display("Fail %s: %s expected %0h, actual %0h", name, what, expV, gotV);
    cycleErrors++;
  endtask

  ////////////////////
  // Walk monitor
  ////////////////////
  // Sampled mid-cycle, inputs move 1 ns after the rising edge
  always @(negedge clk) begin : watch
    int   level;
    paT   expAdr;
    ppnT  basePpn;
    logic missed;
    logic expStall;
    if (active && !reset) begin
      missed = itlbMiss | dtlbMiss;
      // Entry register moves only on the edge after a completing read
      if (pteKnown && (pte !== heldPte)) cycleMismatch("pte register", heldPte, pte);
      if (ptwRead) begin
        level = startLevel - readIdx;
        if (level < 0) begin
          $display("%s read past level 0 at address %h", name, ptwAdr);
          adrErrors++;
        end else begin
          basePpn = (readIdx == 0) ? satpV[ppnBits-1:0] : prevPpn;  // Root comes from SATP
          expAdr  = {basePpn, va[12 + 9*level +: 9], 3'b000};
          if (ptwAdr !== expAdr) begin
            $display("%s read %0d went to address %h instead of %h", name, readIdx, ptwAdr,
                     expAdr);
            adrErrors++;
          end
        end
        if (!memStall) begin
          prevPpn  = readData[53:10];  // Next table base
          heldPte  = readData;
          pteKnown = 1'b1;
          readIdx++;
        end
      end
      if (itlbWrite) itlbCount++;
      if (dtlbWrite) dtlbCount++;
      if (itlbWrite || dtlbWrite) begin
        gotPte  = pte;
        gotType = pageType;
      end
      if (|faultVec) begin
        faultCycles++;
        faultSeen = faultSeen | faultVec;
      end
      // Core held from the first miss cycle through LEAF, released in FAULT
      expStall = missed & ~(|faultVec);
      if (ptwStall !== expStall) cycleMismatch("ptwStall", expStall, ptwStall);
      if ((ptwRead || itlbWrite || dtlbWrite) && (selPtw !== 1'b1))
        cycleMismatch("selPtw", 1'b1, selPtw);
      if (!missed) begin
        // Idle walker drives no control and lets LSU faults through
        if (selPtw !== 1'b0) cycleMismatch("selPtw", 1'b0, selPtw);
        if (ignoreRequest !== 1'b0) cycleMismatch("ignoreRequest", 1'b0, ignoreRequest);
        if (faultVec !== {2'b00, lsuFaults})
          cycleMismatch("idle faults", {2'b00, lsuFaults}, faultVec);
      end
    end
  end

  ////////////////////
  // Per test result
  ////////////////////
  task automatic endTest(input logic timedOut);
    logic ok;
    int   expI;
    int   expD;
    int   expCycles;
    ok        = (adrErrors == 0) && (cycleErrors == 0);
    expI      = ((expFault == '0) && !expData) ? 1 : 0;
    expD      = ((expFault == '0) && expData) ? 1 : 0;
    expCycles = (expFault == '0) ? 0 : 1;   // A fault shows for one cycle
    if (timedOut) begin
      $display("%s timed out with no TLB write and no fault", name);
      ok = 1'b0;
    end
    if ((faultSeen !== expFault) || (faultCycles != expCycles)) begin
      $display("Fail %s: faults expected %b, actual %b over %0d cycles", name, expFault,
               faultSeen, faultCycles);
      ok = 1'b0;
    end
    if ((itlbCount != expI) || (dtlbCount != expD)) begin
      $display("Fail %s: TLB writes expected itlb %0d dtlb %0d, actual itlb %0d dtlb %0d",
               name, expI, expD, itlbCount, dtlbCount);
      ok = 1'b0;
    end
    if (expFault == '0) begin
      if (gotPte !== expPte) begin
        $display("Fail %s: pte expected %h, actual %h", name, expPte, gotPte);
        ok = 1'b0;
      end
      if (gotType !== expType) begin
        $display("Fail %s: pageType expected %0d, actual %0d", name, expType, gotType);
        ok = 1'b0;
      end
    end
    if (ok) begin
      passCount++;
      $display("Pass %s", name);
    end else begin
      failCount++;
    end
    active = 1'b0;
  endtask

  task automatic printCounts();
    $display("%0d tests run, %0d passed, %0d failed", passCount + failCount, passCount,
             failCount);
  endtask

endmodule

//--- sim/tbPageTableWalker.sv
// Page table walker testbench
// Table driven walks against a memory model with LFSR stalls

`timescale 1ns/1ps

module tbPageTableWalker;
  import ptwPkg::*;

  localparam int   numRows   = 6;
  localparam int   waitLimit = 200;  // Cycles per walk before giving up
  localparam xlenT sv39Satp  = 64'h8000_0000_0008_0000;  // Root PPN 0x80000
  localparam xlenT sv48Satp  = 64'h9000_0000_0009_0000;  // Root PPN 0x90000

  // Fault vector {instrAcc, instrPg, loadAcc, storeAcc, loadPg, storePg}
  localparam logic [5:0] noFault  = 6'b000000;
  localparam logic [5:0] instrAcc = 6'b100000;
  localparam logic [5:0] instrPg  = 6'b010000;
  localparam logic [5:0] storeAcc = 6'b000100;
  localparam logic [5:0] loadPg   = 6'b000010;

  logic       clk, reset, flush;
  logic       itlbMiss, dtlbMiss;
  logic [1:0] memRW;
  xlenT       satp, pcAdr, dataAdr, readData, pte;
  paT         ptwAdr;
  pageTypeT   pageType;
  logic       ptwRead, memStall, itlbWrite, dtlbWrite, selPtw, ptwStall, ignoreRequest;
  logic       lsuLoadAccessFault, lsuStoreAmoAccessFault, lsuLoadPageFault, lsuStorePageFault;
  logic       loadAccessFault, storeAmoAccessFault, loadPageFault, storeAmoPageFault;
  logic       instrAccessFault, instrPageFault;
  logic [5:0] faultVec;
  logic [31:0] lfsr;
  int         cur;        // Row served by the memory model
  int         failCount;

  // Walk table
  string      rowName     [numRows];
  logic       rowData     [numRows];  // 1 for a data TLB miss
  logic [1:0] rowRW       [numRows];
  xlenT       rowSatp     [numRows];
  xlenT       rowVa       [numRows];
  paT         rowEntAdr   [numRows][4];
  xlenT       rowEnt      [numRows][4];
  int         rowFaultIdx [numRows];  // Entry whose read faults, -1 for none
  xlenT       rowExpPte   [numRows];
  pageTypeT   rowExpType  [numRows];
  logic [5:0] rowExpFault [numRows];

  assign faultVec = {instrAccessFault, instrPageFault, loadAccessFault, storeAmoAccessFault,
                     loadPageFault, storeAmoPageFault};

  tbClock tbClock_inst (.clk, .reset);

  pageTableWalker pageTableWalker_inst (
    .clk, .reset, .itlbMiss, .dtlbMiss, .memRW, .satp, .pcAdr, .dataAdr, .flush,
    .ptwRead, .ptwAdr, .readData, .memStall, .lsuLoadAccessFault, .lsuStoreAmoAccessFault,
    .lsuLoadPageFault, .lsuStorePageFault, .pte, .pageType, .itlbWrite, .dtlbWrite,
    .selPtw, .ptwStall, .ignoreRequest, .loadAccessFault, .storeAmoAccessFault,
    .loadPageFault, .storeAmoPageFault, .instrAccessFault, .instrPageFault
  );

  tbChecker tbChecker_inst (
    .clk, .reset, .itlbMiss, .dtlbMiss, .ptwRead, .memStall, .ptwAdr, .readData, .pte,
    .pageType, .itlbWrite, .dtlbWrite, .selPtw, .ptwStall, .ignoreRequest,
    .lsuFaults({lsuLoadAccessFault, lsuStoreAmoAccessFault, lsuLoadPageFault,
                lsuStorePageFault}),
    .faultVec, .failCount
  );

  // Galois LFSR, one step per bit
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic setRow(input int i, input string name, input logic data, input logic [1:0] rw,
                        input xlenT satpV, input xlenT va, input int faultIdx,
                        input xlenT expPte, input pageTypeT expType, input logic [5:0] expFault);
    int k;
    rowName[i]     = name;
    rowData[i]     = data;
    rowRW[i]       = rw;
    rowSatp[i]     = satpV;
    rowVa[i]       = va;
    rowFaultIdx[i] = faultIdx;
    rowExpPte[i]   = expPte;
    rowExpType[i]  = expType;
    rowExpFault[i] = expFault;
    for (k = 0; k < 4; k++) begin
      rowEntAdr[i][k] = '1;  // Never matched
      rowEnt[i][k]    = '0;
    end
  endtask

  task automatic setEntry(input int i, input int k, input paT adr, input xlenT val);
    rowEntAdr[i][k] = adr;
    rowEnt[i][k]    = val;
  endtask

  ////////////////////
  // Table
  ////////////////////
  task automatic loadTable();
    setRow(0, "sv39 instr kilopage", 1'b0, 2'b00, sv39Satp, 64'h8060_4000, -1,
           64'h048d_14cf, kiloPage, noFault);
    setEntry(0, 0, 56'h8000_0010, 64'h2000_0401);  // VPN2 2, next table 0x80001
    setEntry(0, 1, 56'h8000_1018, 64'h2000_0801);  // VPN1 3, next table 0x80002
    setEntry(0, 2, 56'h8000_2020, 64'h048d_14cf);  // VPN0 4, leaf RWX with A/D
    setRow(1, "sv39 data gigapage", 1'b1, 2'b10, sv39Satp, 64'h4000_0000, -1,
           64'h1000_00cf, gigaPage, noFault);
    setEntry(1, 0, 56'h8000_0008, 64'h1000_00cf);  // Root entry is the leaf
    setRow(2, "sv48 data megapage", 1'b1, 2'b10, sv48Satp, 64'h0080_80a0_7000, -1,
           64'h0008_00cf, megaPage, noFault);
    setEntry(2, 0, 56'h9000_0008, 64'h2400_0401);  // VPN3 1
    setEntry(2, 1, 56'h9000_1010, 64'h2400_0801);  // VPN2 2
    setEntry(2, 2, 56'h9000_2028, 64'h0008_00cf);  // VPN1 5, leaf
    setRow(3, "sv39 store access fault", 1'b1, 2'b01, sv39Satp, 64'h8060_4000, 1,
           '0, kiloPage, storeAcc);
    setEntry(3, 0, 56'h8000_0010, 64'h2000_0401);
    setEntry(3, 1, 56'h8000_1018, 64'h2000_0801);  // Memory rejects this read
    setRow(4, "sv39 instr access fault", 1'b0, 2'b00, sv39Satp, 64'h8060_4000, 1,
           '0, kiloPage, instrAcc);
    setEntry(4, 0, 56'h8000_0010, 64'h2000_0401);
    setEntry(4, 1, 56'h8000_1018, 64'h2000_0801);
    setRow(5, "sv39 instr pbmt fault", 1'b0, 2'b00, sv39Satp, 64'h8060_4000, -1,
           '0, kiloPage, instrPg);
    setEntry(5, 0, 56'h8000_0010, 64'h2000_0000_2000_0401);  // Non-leaf, PBMT = NC
    setEntry(5, 1, 56'h8000_1018, 64'h2000_0801);
  endtask

  ////////////////////
  // Memory model
  ////////////////////
  always @(posedge clk) begin : memoryModel
    logic stallBitA;
    logic stallBitB;
    int   k;
    #1;
    stallBitA = lfsr[0];
    lfsr      = lfsrNext(lfsr);
    stallBitB = lfsr[0];
    lfsr      = lfsrNext(lfsr);
    memStall  = stallBitA & stallBitB;  // About one cycle in four
    readData  = {8'h00, ptwAdr};        // Unmapped or stalled, V bit clear
    lsuLoadAccessFault = 1'b0;
    // Entry and fault only valid on the completing cycle
    if (ptwRead && !memStall) begin
      for (k = 0; k < 4; k++) begin
        if (ptwAdr == rowEntAdr[cur][k]) begin
          readData           = rowEnt[cur][k];
          lsuLoadAccessFault = (k == rowFaultIdx[cur]);
        end
      end
    end
  end

  task automatic settle();
    repeat (3) @(posedge clk);  // Room for a stray second strobe
    #1;
    flush = 1'b0;
  endtask

  task automatic runRow(input int i);
    int   cycles;
    logic finished;
    @(posedge clk);
    #1;
    cur     = i;
    memRW   = rowRW[i];
    satp    = rowSatp[i];
    pcAdr   = rowData[i] ? ~rowVa[i] : rowVa[i];  // Other side holds a decoy
    dataAdr = rowData[i] ? rowVa[i] : ~rowVa[i];
    tbChecker_inst.startTest(rowName[i], rowSatp[i], rowVa[i], rowData[i], rowExpPte[i],
                             rowExpType[i], rowExpFault[i]);
    itlbMiss = ~rowData[i];
    dtlbMiss = rowData[i];
    cycles   = 0;
    finished = 1'b0;
    while (!finished && cycles < waitLimit) begin
      @(negedge clk);
      finished = itlbWrite | dtlbWrite | (|faultVec);
      cycles++;
    end
    @(posedge clk);
    #1;
    itlbMiss = 1'b0;
    dtlbMiss = 1'b0;
    flush    = ~finished;  // Abort a stuck walk
    settle();
    tbChecker_inst.endTest(~finished);
  endtask

  // LSU fault while the walker is idle
  task automatic idleFaultPass();
    @(posedge clk);
    #1;
    tbChecker_inst.startTest("idle lsu load page fault", satp, '0, 1'b1, '0, kiloPage, loadPg);
    lsuLoadPageFault = 1'b1;
    @(posedge clk);
    #1;
    lsuLoadPageFault = 1'b0;
    settle();
    tbChecker_inst.endTest(1'b0);
  endtask

  initial begin : stimulus
    int waited;
    int i;
    itlbMiss = 1'b0;
    dtlbMiss = 1'b0;
    memRW    = 2'b00;
    satp     = '0;
    pcAdr    = '0;
    dataAdr  = '0;
    flush    = 1'b0;
    readData = '0;
    memStall = 1'b0;
    lsuLoadAccessFault     = 1'b0;
    lsuStoreAmoAccessFault = 1'b0;
    lsuLoadPageFault       = 1'b0;
    lsuStorePageFault      = 1'b0;
    lfsr     = 32'hdcc3;
    cur      = 0;
    loadTable();
    waited = 0;
    while (reset !== 1'b0 && waited < 10) begin
      @(posedge clk);
      waited++;
    end
    if (reset !== 1'b0) begin
      $display("Reset was never released");
      $display("Something failed");
      $finish;
    end else begin
      for (i = 0; i < numRows; i++) runRow(i);
      idleFaultPass();
      tbChecker_inst.printCounts();
      if (failCount == 0) $display("Everything OK");
      else $display("Something failed");
      $finish;
    end
  end

endmodule

//--- filelist.f
design/ptwPkg.sv
design/walkAddrGen.sv
design/pteCapture.sv
design/walkFsm.sv
design/walkFaults.sv
design/pageTableWalker.sv
sim/tbClock.sv
sim/tbChecker.sv
sim/tbPageTableWalker.sv

//--- Bender.yml
package:
  name: pageTableWalker

sources:
  - design/ptwPkg.sv
  - design/walkAddrGen.sv
  - design/pteCapture.sv
  - design/walkFsm.sv
  - design/walkFaults.sv
  - design/pageTableWalker.sv
  - target: test
    files:
      - sim/tbClock.sv
      - sim/tbChecker.sv
      - sim/tbPageTableWalker.sv
